/* hw/sd_pkg.sv */
// Shared widths, SD command indices, arguments and tokens
// Reply kinds, sequencer states and the CRC7/CRC16 byte functions
package sd_pkg;

  typedef logic [31:0] sd_addr_t;       // Block address and command argument
  typedef logic [5:0]  sd_cmd_index_t;
  typedef logic [7:0]  sd_byte_t;
  typedef logic [15:0] crc16_t;

  localparam int BLOCK_BYTES_DEFAULT = 512;

  localparam sd_cmd_index_t CMD_GO_IDLE      = 6'd0;
  localparam sd_cmd_index_t CMD_SEND_IF_COND = 6'd8;
  localparam sd_cmd_index_t CMD_CRC_ON       = 6'd59;
  localparam sd_cmd_index_t CMD_APP          = 6'd55;
  localparam sd_cmd_index_t ACMD_SD_OP_COND  = 6'd41;
  localparam sd_cmd_index_t CMD_READ_BLOCK   = 6'd17;
  localparam sd_cmd_index_t CMD_WRITE_BLOCK  = 6'd24;
  localparam sd_cmd_index_t CMD_SEND_STATUS  = 6'd13;

  localparam sd_addr_t IF_COND_ARG = 32'h0000_01AA;  // 2.7-3.6 V, pattern AA
  localparam sd_addr_t HCS_ARG     = 32'h4000_0000;

  localparam sd_byte_t   START_TOKEN   = 8'hFE;
  localparam logic [2:0] DATA_ACCEPTED = 3'b010;
  localparam sd_byte_t   R1_IDLE       = 8'h01;
  localparam sd_byte_t   R1_ILLEGAL    = 8'h04;

  typedef enum logic [2:0] {
    RESP_R1,
    RESP_R7,             // R1 plus 4 bytes
    RESP_R2,             // R1 plus status byte
    RESP_DATA_BLOCK,
    RESP_DATA_RESPONSE
  } resp_kind_t;

  typedef enum logic [3:0] {
    SEQ_CMD0,
    SEQ_CMD8,
    SEQ_CMD59,
    SEQ_CMD55,
    SEQ_ACMD41,
    SEQ_IDLE,
    SEQ_CMD17,
    SEQ_READ_DATA,
    SEQ_CMD24,
    SEQ_WRITE_DATA,
    SEQ_WAIT_BUSY,
    SEQ_CMD13
  } seq_state_t;

  // One byte of CRC7, x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7(input logic [6:0] crc, input sd_byte_t data);
    logic [6:0] c;
    logic       fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[6] ^ data[i];
      c  = {c[5:0], 1'b0};
      if (fb) c = c ^ 7'h09;
    end
    return c;
  endfunction

  // One byte of CRC16-CCITT, zero seed
  function automatic crc16_t crc16(input crc16_t crc, input sd_byte_t data);
    crc16_t c;
    logic   fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0};
      if (fb) c = c ^ 16'h1021;
    end
    return c;
  endfunction

endpackage

/* hw/sd_sender.sv */
// Command frame and data block serializer
// Drives mosi MSB first and divides clock by two for sck
`timescale 1ns/100ps

module sd_sender import sd_pkg::*; #(
  parameter int block_bytes = BLOCK_BYTES_DEFAULT
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     send_valid,
  input  logic                     send_data_phase,
  input  sd_cmd_index_t            cmd_index,
  input  sd_addr_t                 argument,
  input  logic [block_bytes*8-1:0] block,
  input  logic                     recv_active,
  output logic                     send_done,
  output logic                     sck,
  output logic                     mosi
);

  localparam int FRAME_BITS = (block_bytes + 3) * 8;  // Token, block, CRC16
  localparam int CNT_W      = $clog2(FRAME_BITS + 1);

  logic [FRAME_BITS-1:0] shreg;
  logic [FRAME_BITS-1:0] load_frame;
  logic [CNT_W-1:0]      bit_cnt;
  logic                  active;
  logic [6:0]            cmd_crc;
  crc16_t                block_crc;

  always_comb begin
    cmd_crc = crc7(7'h00, {2'b01, cmd_index});
    for (int i = 3; i >= 0; i--) cmd_crc = crc7(cmd_crc, argument[i*8 +: 8]);
    block_crc = '0;
    for (int i = block_bytes - 1; i >= 0; i--) block_crc = crc16(block_crc, block[i*8 +: 8]);
    if (send_data_phase) begin
      load_frame = {START_TOKEN, block, block_crc};
    end else begin
      load_frame = {2'b01, cmd_index, argument, cmd_crc, 1'b1, {(FRAME_BITS - 48){1'b1}}};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      active    <= 1'b0;
      sck       <= 1'b0;
      mosi      <= 1'b1;
      send_done <= 1'b0;
      bit_cnt   <= '0;
    end else begin
      send_done <= 1'b0;
      if (sck) sck <= 1'b0;
      else if (active || recv_active) sck <= 1'b1;

      if (!active) begin
        if (send_valid) begin
          active  <= 1'b1;
          mosi    <= load_frame[FRAME_BITS-1];
          bit_cnt <= send_data_phase ? CNT_W'(FRAME_BITS) : CNT_W'(48);
        end
      end else if (!sck) begin
        if (bit_cnt == CNT_W'(1)) send_done <= 1'b1;  // Last rising edge
      end else if (bit_cnt == CNT_W'(1)) begin
        active <= 1'b0;
        mosi   <= 1'b1;
      end else begin
        mosi    <= shreg[FRAME_BITS-2];  // Next bit on the falling edge
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!active && send_valid) shreg <= load_frame;
    else if (active && sck) shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
  end

endmodule

/* hw/sd_receiver.sv */
// Reply collector on miso
// Skips idle bytes, gathers R1/R7/R2, tokens and data blocks, checks CRC16
`timescale 1ns/100ps

module sd_receiver import sd_pkg::*; #(
  parameter int block_bytes = BLOCK_BYTES_DEFAULT
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     recv_valid,
  input  resp_kind_t               resp_kind,
  input  logic                     sck,
  input  logic                     miso,
  output logic                     recv_done,
  output logic                     recv_active,
  output logic [39:0]              response,
  output logic [block_bytes*8-1:0] read_data,
  output logic                     crc_error
);

  localparam int CNT_W = $clog2(block_bytes + 3);

  typedef enum logic [1:0] {RX_IDLE, RX_HUNT, RX_COLLECT} rx_state_t;

  rx_state_t        state;
  logic [2:0]       bit_cnt;
  logic [3:0]       hunt_cnt;  // Up to 16 idle bytes
  logic [CNT_W-1:0] bytes_left;
  logic [CNT_W-1:0] extra_bytes;
  sd_byte_t         shift_byte;
  sd_byte_t         byte_in;
  sd_byte_t         crc_hi;
  crc16_t           crc_calc;
  logic             sample;
  logic             byte_done;
  logic             is_block;

  assign recv_active = (state != RX_IDLE);
  assign sample      = recv_active && !sck;  // sck rises on this edge
  assign byte_in     = {shift_byte[6:0], miso};
  assign byte_done   = sample && (bit_cnt == 3'd7);
  assign is_block    = (resp_kind == RESP_DATA_BLOCK);

  always_comb begin
    case (resp_kind)
      RESP_R7: extra_bytes = CNT_W'(4);
      RESP_R2: extra_bytes = CNT_W'(1);
      default: extra_bytes = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= RX_IDLE;
      recv_done  <= 1'b0;
      bit_cnt    <= '0;
      hunt_cnt   <= '0;
      bytes_left <= '0;
      crc_error  <= 1'b0;
    end else begin
      recv_done <= 1'b0;
      if (state == RX_IDLE) begin
        if (recv_valid && !recv_done) begin
          state     <= RX_HUNT;
          bit_cnt   <= '0;
          hunt_cnt  <= '0;
          crc_error <= 1'b0;
        end
      end else if (sample) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (byte_done && state == RX_HUNT) begin
          if (byte_in == 8'hFF) begin
            hunt_cnt <= hunt_cnt + 1'b1;
            if (hunt_cnt == 4'd15) begin  // Timeout, reported as 0xFF
              state     <= RX_IDLE;
              recv_done <= 1'b1;
            end
          end else if (is_block && byte_in == START_TOKEN) begin
            state      <= RX_COLLECT;
            bytes_left <= CNT_W'(block_bytes + 2);
          end else if (is_block || extra_bytes == '0) begin
            state     <= RX_IDLE;  // Single byte reply or error token
            recv_done <= 1'b1;
          end else begin
            state      <= RX_COLLECT;
            bytes_left <= extra_bytes;
          end
        end else if (byte_done) begin
          bytes_left <= bytes_left - 1'b1;
          if (bytes_left == CNT_W'(1)) begin
            state     <= RX_IDLE;
            recv_done <= 1'b1;
            if (is_block) crc_error <= (crc_calc != {crc_hi, byte_in});
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == RX_IDLE) crc_calc <= '0;
    if (sample) shift_byte <= byte_in;
    if (byte_done) begin
      if (state == RX_HUNT) begin
        response <= {32'h0, byte_in};
      end else if (!is_block) begin
        response <= {response[31:0], byte_in};
      end else if (bytes_left > CNT_W'(2)) begin
        read_data <= {read_data[block_bytes*8-9:0], byte_in};
        crc_calc  <= crc16(crc_calc, byte_in);
      end else begin
        crc_hi <= byte_in;  // High CRC byte, low one is compared live
      end
    end
  end

endmodule

/* hw/sd_sequencer.sv */
// Start-up and block transfer FSM for the SD controller
// Picks each command, requests the reply and judges it
`timescale 1ns/100ps

module sd_sequencer import sd_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          rd_en,
  input  logic          wr_en,
  input  sd_addr_t      addr,
  output logic          busy,
  output logic          cs,
  output sd_cmd_index_t cmd_index,
  output sd_addr_t      argument,
  output logic          send_valid,
  output logic          send_data_phase,
  input  logic          send_done,
  output logic          recv_valid,
  output resp_kind_t    resp_kind,
  input  logic          recv_done,
  input  logic [39:0]   response,
  input  logic          crc_error,
  output logic          block_load
);

  seq_state_t state;
  seq_state_t next_state;
  logic       phase_recv;  // Command sent, waiting on the receiver
  logic       next_recv;
  logic       recv_only;
  sd_addr_t   addr_q;
  sd_byte_t   r1;

  assign r1        = response[7:0];
  assign recv_only = (state == SEQ_READ_DATA) || (state == SEQ_WAIT_BUSY);

  assign busy            = (state != SEQ_IDLE);
  assign block_load      = (state == SEQ_IDLE) && wr_en;
  assign send_valid      = busy && !recv_only && !phase_recv;
  assign send_data_phase = (state == SEQ_WRITE_DATA);
  assign recv_valid      = phase_recv;

  always_comb begin
    cmd_index = CMD_GO_IDLE;
    argument  = '0;
    resp_kind = RESP_R1;
    case (state)
      SEQ_CMD8: begin
        cmd_index = CMD_SEND_IF_COND;
        argument  = IF_COND_ARG;
        resp_kind = RESP_R7;
      end
      SEQ_CMD59: begin
        cmd_index = CMD_CRC_ON;
        argument  = 32'd1;  // CRC option on
      end
      SEQ_CMD55:  cmd_index = CMD_APP;
      SEQ_ACMD41: begin
        cmd_index = ACMD_SD_OP_COND;
        argument  = HCS_ARG;
      end
      SEQ_CMD17: begin
        cmd_index = CMD_READ_BLOCK;
        argument  = addr_q;
      end
      SEQ_READ_DATA: resp_kind = RESP_DATA_BLOCK;
      SEQ_CMD24: begin
        cmd_index = CMD_WRITE_BLOCK;
        argument  = addr_q;
      end
      SEQ_WRITE_DATA: resp_kind = RESP_DATA_RESPONSE;
      SEQ_CMD13: begin
        cmd_index = CMD_SEND_STATUS;
        resp_kind = RESP_R2;
      end
      default: ;
    endcase
  end

  always_comb begin
    next_state = state;
    next_recv  = phase_recv;
    if (state == SEQ_IDLE) begin
      if (wr_en) next_state = SEQ_CMD24;
      else if (rd_en) next_state = SEQ_CMD17;
    end else if (!phase_recv) begin
      if (recv_only || send_done) next_recv = 1'b1;
    end else if (recv_done) begin
      next_recv = 1'b0;
      case (state)
        SEQ_CMD0: if (r1 == R1_IDLE) next_state = SEQ_CMD8;
        SEQ_CMD8: begin
          if ((response[39:32] & R1_ILLEGAL) != '0) begin
            next_state = SEQ_CMD55;  // Version 1 card, no pattern echo
          end else if (response[11:0] == IF_COND_ARG[11:0]) begin
            next_state = SEQ_CMD59;
          end
        end
        SEQ_CMD59:  if (r1 == R1_IDLE) next_state = SEQ_CMD55;
        SEQ_CMD55:  if (r1 == R1_IDLE) next_state = SEQ_ACMD41;
        SEQ_ACMD41: next_state = (r1 == '0) ? SEQ_IDLE : SEQ_CMD55;
        SEQ_CMD17:  next_state = (r1 == '0) ? SEQ_READ_DATA : SEQ_IDLE;
        SEQ_READ_DATA: begin
          if (r1 == START_TOKEN && !crc_error) next_state = SEQ_IDLE;
          else if (r1[7:4] == 4'h0 && r1[3]) next_state = SEQ_IDLE;  // Out of range
          else next_state = SEQ_CMD17;
        end
        SEQ_CMD24: next_state = (r1 == '0) ? SEQ_WRITE_DATA : SEQ_IDLE;
        SEQ_WRITE_DATA: begin
          next_state = (r1[3:1] == DATA_ACCEPTED) ? SEQ_WAIT_BUSY : SEQ_CMD24;
        end
        SEQ_WAIT_BUSY: if (r1 != '0) next_state = SEQ_CMD13;  // Card released miso
        SEQ_CMD13:     next_state = SEQ_IDLE;
        default:       next_state = SEQ_CMD0;
      endcase
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= SEQ_CMD0;
      phase_recv <= 1'b0;
      cs         <= 1'b1;
    end else begin
      state      <= next_state;
      phase_recv <= next_recv;
      cs         <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (state == SEQ_IDLE && (rd_en || wr_en)) addr_q <= addr;
  end

endmodule

/* hw/sd_controller.sv */
// SPI-mode SD card controller top level
// Write block register plus sequencer, sender and receiver
`timescale 1ns/100ps

module sd_controller import sd_pkg::*; #(
  parameter int block_bytes = BLOCK_BYTES_DEFAULT
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     rd_en,
  input  logic                     wr_en,
  input  sd_addr_t                 addr,
  input  logic [block_bytes*8-1:0] write_data,
  output logic [block_bytes*8-1:0] read_data,
  output logic                     busy,
  input  logic                     miso,
  output logic                     cs,
  output logic                     sck,
  output logic                     mosi
);

  logic                     send_valid;
  logic                     send_data_phase;
  logic                     send_done;
  sd_cmd_index_t            cmd_index;
  sd_addr_t                 argument;
  logic                     recv_valid;
  logic                     recv_done;
  logic                     recv_active;
  logic                     crc_error;
  resp_kind_t               resp_kind;
  logic [39:0]              response;
  logic                     block_load;
  logic [block_bytes*8-1:0] write_block;

  always_ff @(posedge clock) begin
    if (block_load) write_block <= write_data;  // Held for CMD24 retries
  end

  sd_sequencer u_sequencer (
    .clock           (clock),
    .reset           (reset),
    .rd_en           (rd_en),
    .wr_en           (wr_en),
    .addr            (addr),
    .busy            (busy),
    .cs              (cs),
    .cmd_index       (cmd_index),
    .argument        (argument),
    .send_valid      (send_valid),
    .send_data_phase (send_data_phase),
    .send_done       (send_done),
    .recv_valid      (recv_valid),
    .resp_kind       (resp_kind),
    .recv_done       (recv_done),
    .response        (response),
    .crc_error       (crc_error),
    .block_load      (block_load)
  );

  sd_sender #(.block_bytes(block_bytes)) u_sender (
    .clock           (clock),
    .reset           (reset),
    .send_valid      (send_valid),
    .send_data_phase (send_data_phase),
    .cmd_index       (cmd_index),
    .argument        (argument),
    .block           (write_block),
    .recv_active     (recv_active),
    .send_done       (send_done),
    .sck             (sck),
    .mosi            (mosi)
  );

  sd_receiver #(.block_bytes(block_bytes)) u_receiver (
    .clock       (clock),
    .reset       (reset),
    .recv_valid  (recv_valid),
    .resp_kind   (resp_kind),
    .sck         (sck),
    .miso        (miso),
    .recv_done   (recv_done),
    .recv_active (recv_active),
    .response    (response),
    .read_data   (read_data),
    .crc_error   (crc_error)
  );

endmodule

/* verification/sd_card_model.sv */
// Behavioral SPI-mode SD card with a small block memory
// Counts commands, checks CRC7 and CRC16, injects faults per test
`timescale 1ns/100ps

module sd_card_model #(
  parameter int block_bytes = 8
) (
  input  logic       reset,
  input  logic       cs,
  input  logic       sck,
  input  logic       mosi,
  output logic       miso,
  input  logic [3:0] fault,
  input  int         test_id,
  input  int         busy_count
);

  localparam int MEM_BLOCKS = 64;
  localparam int DATA_BITS  = (block_bytes + 2) * 8;

  logic [7:0]           mem [0:MEM_BLOCKS*block_bytes-1];
  logic [7:0]           out_q [$];
  logic [7:0]           out_byte;
  logic [47:0]          frame;
  logic [DATA_BITS-1:0] data_sr;
  logic [15:0]          crc;
  logic [6:0]           c7;
  logic                 in_frame, wait_token, in_data, app, idle, accepted;
  int out_bit, nbits, wr_addr, crc_bad_id, cmd8_bad_id;
  int cmd0_count, cmd8_count, cmd59_count, cmd55_count, acmd41_count;
  int cmd17_count, cmd24_count, cmd13_after_accept, crc7_errors, bad_args, good_writes;

  function automatic logic [6:0] crc7_bit(input logic [6:0] c, input logic b);
    return (c[6] ^ b) ? ({c[5:0], 1'b0} ^ 7'h09) : {c[5:0], 1'b0};
  endfunction

  function automatic logic [15:0] crc16_bit(input logic [15:0] c, input logic b);
    return (c[15] ^ b) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
  endfunction

  task automatic send_block(input int blk, input logic corrupt);
    logic [15:0] c;
    c = '0;
    out_q.push_back(8'hFE);
    for (int i = 0; i < block_bytes; i++) begin
      out_q.push_back(mem[blk*block_bytes + i]);
      for (int j = 7; j >= 0; j--) c = crc16_bit(c, mem[blk*block_bytes + i][j]);
    end
    out_q.push_back(c[15:8]);
    out_q.push_back(c[7:0] ^ {7'd0, corrupt});  // Bad CRC on request
  endtask

  task automatic decode_frame();
    logic [5:0]  idx;
    logic [31:0] arg;
    idx = frame[45:40];
    arg = frame[39:8];
    c7  = '0;
    for (int i = 47; i >= 8; i--) c7 = crc7_bit(c7, frame[i]);
    if (c7 != frame[7:1] || !frame[0]) crc7_errors++;
    out_q.push_back(8'hFF);
    if (app && idx == 6'd41) begin
      acmd41_count++;
      if (arg != 32'h4000_0000) bad_args++;
      if (acmd41_count > busy_count) idle = 1'b0;
      out_q.push_back(idle ? 8'h01 : 8'h00);
    end else begin
      case (idx)
        6'd0: begin
          cmd0_count++;
          idle = 1'b1;
          out_q.push_back(8'h01);
        end
        6'd8: begin
          cmd8_count++;
          if (arg != 32'h0000_01AA) bad_args++;
          out_q.push_back(8'h01);
          out_q.push_back(8'h00);
          out_q.push_back(8'h00);
          out_q.push_back({4'h0, arg[11:8]});
          if (fault == 4'd3 && cmd8_bad_id != test_id) begin
            cmd8_bad_id = test_id;
            out_q.push_back(8'h55);  // Wrong echo, once
          end else begin
            out_q.push_back(arg[7:0]);
          end
        end
        6'd59: begin
          cmd59_count++;
          out_q.push_back(8'h01);
        end
        6'd55: begin
          cmd55_count++;
          out_q.push_back(idle ? 8'h01 : 8'h00);
        end
        6'd17: begin
          cmd17_count++;
          out_q.push_back(8'h00);
          out_q.push_back(8'hFF);
          if (arg >= MEM_BLOCKS) begin
            out_q.push_back(8'h08);  // Out of range error token
          end else if (fault == 4'd1 && crc_bad_id != test_id) begin
            crc_bad_id = test_id;
            send_block(int'(arg), 1'b1);
          end else begin
            send_block(int'(arg), 1'b0);
          end
        end
        6'd24: begin
          cmd24_count++;
          wr_addr    = int'(arg);
          wait_token = 1'b1;
          out_q.push_back(8'h00);
        end
        6'd13: begin
          if (accepted) cmd13_after_accept++;
          accepted = 1'b0;
          out_q.push_back(8'h00);
          out_q.push_back(8'h00);
        end
        default: out_q.push_back(8'h04);
      endcase
    end
    app = (idx == 6'd55);
  endtask

  task automatic finish_write();
    crc = '0;
    for (int i = DATA_BITS - 1; i >= 16; i--) crc = crc16_bit(crc, data_sr[i]);
    out_q.push_back(8'hFF);
    if (crc == data_sr[15:0] && wr_addr < MEM_BLOCKS) begin
      good_writes++;
      for (int i = 0; i < block_bytes; i++) begin
        mem[wr_addr*block_bytes + i] = data_sr[DATA_BITS-1-8*i -: 8];
      end
      accepted = 1'b1;
      out_q.push_back(8'h05);
      repeat (3) out_q.push_back(8'h00);  // Busy while programming
    end else begin
      out_q.push_back(8'h0B);
    end
  endtask

  always @(posedge reset or posedge sck or negedge sck) begin
    if (reset) begin
      out_q.delete();
      miso = 1'b1;
      {in_frame, wait_token, in_data, app, idle, accepted} = '0;
      out_bit = 0;
      crc_bad_id  = -1;
      cmd8_bad_id = -1;
      {cmd0_count, cmd8_count, cmd59_count, cmd55_count, acmd41_count} = '0;
      {cmd17_count, cmd24_count, cmd13_after_accept, crc7_errors, bad_args, good_writes} = '0;
    end else if (cs) begin
      miso = 1'b1;
    end else if (sck) begin
      if (in_data) begin
        data_sr = {data_sr[DATA_BITS-2:0], mosi};
        nbits++;
        if (nbits == DATA_BITS) begin
          in_data = 1'b0;
          finish_write();
        end
      end else if (wait_token) begin
        if (!mosi) begin  // Last bit of the start token
          wait_token = 1'b0;
          in_data    = 1'b1;
          nbits      = 0;
        end
      end else if (!in_frame) begin
        if (!mosi) begin
          in_frame = 1'b1;
          frame    = '0;
          nbits    = 1;
        end
      end else begin
        frame = {frame[46:0], mosi};
        nbits++;
        if (nbits == 48) begin
          in_frame = 1'b0;
          decode_frame();
        end
      end
    end else begin
      if (out_bit == 0 && out_q.size() > 0) begin
        out_byte = out_q.pop_front();
        out_bit  = 8;
      end
      if (out_bit > 0) begin
        out_bit--;
        miso = out_byte[out_bit];
      end else begin
        miso = 1'b1;
      end
    end
  end

endmodule

/* verification/sd_controller_sva.sv */
// Handshake and pin assertions for the SD sequencer
`timescale 1ns/100ps

module sd_controller_sva import sd_pkg::*; (
  input logic       clock,
  input logic       reset,
  input seq_state_t state,
  input logic       busy,
  input logic       cs,
  input logic       send_valid,
  input logic       send_done,
  input logic       recv_valid,
  input logic       recv_done
);

  // A transfer or start-up ends only on the reply to its last step
  busy_fall_idle: assert property (@(posedge clock) disable iff (reset)
    $fell(busy) |-> $past(recv_done) &&
      ($past(state) inside {SEQ_ACMD41, SEQ_CMD17, SEQ_READ_DATA, SEQ_CMD24, SEQ_CMD13}))
    else $error("busy fell outside a terminal state");

  cs_held_low: assert property (@(posedge clock) disable iff (reset)
    !cs |=> !cs) else $error("cs rose after start-up");

  one_request: assert property (@(posedge clock) disable iff (reset)
    !(send_valid && recv_done) && !(recv_valid && send_done))
    else $error("send and receive handshakes overlap");

  send_hold: assert property (@(posedge clock) disable iff (reset)
    send_valid && !send_done |=> send_valid) else $error("send_valid dropped before send_done");

endmodule

/* verification/tb_sd_controller.sv */
// Testbench top for the SD controller with a card model
// Stimulus and expected counts from the stim file
`timescale 1ns/100ps

module tb_sd_controller;
  import sd_pkg::*;

  localparam int BLOCK_BYTES = 8;

  logic                     clock, reset, rd_en, wr_en, miso, cs, sck, mosi, busy;
  sd_addr_t                 addr;
  logic [BLOCK_BYTES*8-1:0] write_data, read_data, block;
  logic [BLOCK_BYTES*8-1:0] written [int];
  logic [3:0]               fault;
  int test_id, busy_count, cycles, limit, fd, n, c17, c13, c24, gw;
  int op_q[$], addr_q[$], seed_q[$], fault_q[$], expect_q[$];
  int op, a, s, f, e;
  string line;

  sd_controller #(.block_bytes(BLOCK_BYTES)) DUT (.*);

  sd_card_model #(.block_bytes(BLOCK_BYTES)) card (
    .reset(reset), .cs(cs), .sck(sck), .mosi(mosi), .miso(miso),
    .fault(fault), .test_id(test_id), .busy_count(busy_count)
  );

  bind sd_sequencer sd_controller_sva sva (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: busy did not fall within %0d cycles", limit);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic wait_idle();
    do @(negedge clock); while (busy);
  endtask

  function automatic logic [BLOCK_BYTES*8-1:0] make_block(input int seed_value);
    int seed;
    logic [BLOCK_BYTES*8-1:0] b;
    seed = 32'h98e8 + seed_value;
    for (int i = 0; i < BLOCK_BYTES; i++) b[i*8 +: 8] = 8'($random(seed));
    return b;
  endfunction

  initial begin
    rd_en = 1'b0;
    wr_en = 1'b0;
    reset <= 1'b1;
    addr = '0;
    write_data = '0;
    {fault, test_id, busy_count, cycles, limit} = '0;
    limit = 1000000;
    fd = $fopen("verification/sd_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      $display("Some tests failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%h %h %h %h %h", op, a, s, f, e) == 5) begin
        op_q.push_back(op);
        addr_q.push_back(a);
        seed_q.push_back(s);
        fault_q.push_back(f);
        expect_q.push_back(e);
      end
    end
    $fclose(fd);
    limit = op_q.size() * (BLOCK_BYTES + 40) * 16 * 4 + 20000;  // Last term is start-up

    // Start-up line first
    busy_count = seed_q[0];
    fault      = 4'(fault_q[0]);
    repeat (8) @(posedge clock);
    check(busy && cs && !sck && mosi, "wrong pin levels during reset");
    reset <= 1'b0;
    wait_idle();
    check(!cs, "cs not low after start-up");
    check(card.cmd0_count == 1, "wrong CMD0 count");
    check(card.cmd8_count == expect_q[0], "wrong CMD8 count");
    check(card.cmd59_count == 1, "wrong CMD59 count");
    check(card.acmd41_count == busy_count + 1, "wrong ACMD41 count");
    check(card.cmd55_count == busy_count + 1, "wrong CMD55 count");

    for (int t = 1; t < op_q.size(); t++) begin
      c17 = card.cmd17_count;
      c13 = card.cmd13_after_accept;
      c24 = card.cmd24_count;
      gw  = card.good_writes;
      block = make_block(seed_q[t]);
      @(posedge clock);
      test_id    <= t;
      fault      <= 4'(fault_q[t]);
      addr       <= sd_addr_t'(addr_q[t]);
      write_data <= block;
      wr_en      <= (op_q[t] == 1);
      rd_en      <= (op_q[t] == 2);
      @(posedge clock);
      {wr_en, rd_en} <= 2'b00;
      wait_idle();
      if (op_q[t] == 1) begin
        written[addr_q[t]] = block;
        check(card.cmd24_count == c24 + 1, "wrong CMD24 count");
        check(card.good_writes == gw + 1, "write block not accepted with good CRC16");
        check(card.cmd13_after_accept == c13 + expect_q[t], "no CMD13 after accept");
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          check(card.mem[addr_q[t]*BLOCK_BYTES + i] == block[(BLOCK_BYTES-1-i)*8 +: 8],
                "card memory differs from written block");
        end
      end else begin
        check(card.cmd17_count == c17 + expect_q[t], "wrong CMD17 count");
        if (fault_q[t] != 2) begin
          check(read_data == written[addr_q[t]], "read_data differs from written block");
        end
      end
    end
    check(card.crc7_errors == 0, "bad CRC7 on a command frame");
    check(card.bad_args == 0, "bad CMD8 or ACMD41 argument");
    $display("All tests passed");
    $finish;
  end

endmodule

/* compile.f */
hw/sd_pkg.sv
hw/sd_sender.sv
hw/sd_receiver.sv
hw/sd_sequencer.sv
hw/sd_controller.sv
verification/sd_card_model.sv
verification/sd_controller_sva.sv
verification/tb_sd_controller.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sd_controller
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
STIM      = verification/sd_stim.txt

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM) $(STIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* verification/sd_stim.txt */
# op addr seed fault expect (all hex)
# op 0 start-up: seed = ACMD41 busy count, fault 3 = bad CMD8 echo, expect = CMD8 count
# op 1 write: expect = CMD13 count, op 2 read: fault 1 = bad CRC, 2 = error token, expect = CMD17 count
0 0 3 3 2
1 5 11 0 1
1 c 22 0 1
2 5 0 0 1
2 c 0 1 2
1 3f 33 0 1
2 3f 0 0 1
2 100 0 2 1
2 5 0 1 2
